// File: rtl/fetch_params.svh
/* widths, queue depth, boot address and opcode constants for fetch
   QUEUE_DEPTH must be at least 2 so that almost-full leaves room for one read */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// one word of data and address
`define XLEN 32

`define QUEUE_DEPTH 8

`define BOOT_PC 32'h0000_0100

// rv32i opcode field values
`define OP_JAL 7'b1101111
`define OP_BRANCH 7'b1100011

`define INSTR_ECALL 32'h0000_0073

`endif

// File: rtl/fetch_pkg.sv
/* types shared by the fetch front end; widths come from fetch_params.svh */
`include "fetch_params.svh"

package fetch_pkg;

	// byte address
	typedef logic [`XLEN-1:0] addr_t;

	// raw instruction word
	typedef logic [`XLEN-1:0] instr_t;

	typedef struct packed {
		addr_t pc;
		instr_t instr;
	} queue_entry_t;

	// predecoded word as it leaves fetch
	typedef struct packed {
		addr_t pc;
		instr_t instr;
		logic is_ecall;
		logic is_branch;
		logic taken;
		addr_t target;
	} issue_t;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_R,
		HALT
	} fetch_state_t;

endpackage

// File: rtl/fetch_ctrl.sv
/* pc and fetch FSM; one read outstanding at most
   a redirect during a read marks the returning word for drop */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_ctrl (
	input logic clk,
	input logic rst_n,
	input logic go,
	input logic redirect_valid,
	input fetch_pkg::addr_t redirect_pc,
	output logic req_valid,
	output fetch_pkg::addr_t req_addr,
	input logic req_ready,
	input logic resp_valid,
	input fetch_pkg::instr_t resp_data,
	output logic push,
	output fetch_pkg::queue_entry_t push_entry,
	output logic flush,
	input logic almost_full
);

	import fetch_pkg::*;

	fetch_state_t state, state_nxt;
	addr_t pc, pc_nxt;
	logic drop, drop_nxt;
	logic req_fire;
	logic resp_ecall;

	// stop requesting while the queue could not take the word
	assign req_valid = (state == REQ) && !almost_full;
	assign req_addr = pc;
	assign req_fire = req_valid && req_ready;

	assign flush = redirect_valid;
	assign push_entry = '{pc: pc, instr: resp_data};
	assign push = (state == WAIT_R) && resp_valid && !drop && !redirect_valid;
	assign resp_ecall = (resp_data == `INSTR_ECALL);

	always_comb begin
		state_nxt = state;
		pc_nxt = pc;
		drop_nxt = drop;
		case (state)
			IDLE, HALT: begin
				if (go)
					state_nxt = REQ;
			end
			REQ: begin
				if (req_fire)
					state_nxt = WAIT_R;
			end
			WAIT_R: begin
				if (resp_valid) begin
					drop_nxt = 1'b0;
					if (push) begin
						pc_nxt = pc + `XLEN'd4;
						state_nxt = resp_ecall ? HALT : REQ;
					end else begin
						state_nxt = REQ;
					end
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase

		// redirect wins over the sequential pc
		if (redirect_valid) begin
			pc_nxt = redirect_pc;
			if (req_fire || (state == WAIT_R && !resp_valid))
				drop_nxt = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			pc <= `BOOT_PC;
			drop <= 1'b0;
		end else begin
			state <= state_nxt;
			pc <= pc_nxt;
			drop <= drop_nxt;
		end
	end

endmodule

// File: rtl/axil_read_master.sv
/* AXI-Lite read channels only, one transaction at a time
   rresp is not checked; resp_valid follows the R transfer by one cycle */
`timescale 1ns/1ns

module axil_read_master (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	input fetch_pkg::addr_t req_addr,
	output logic req_ready,
	output logic resp_valid,
	output fetch_pkg::instr_t resp_data,
	output fetch_pkg::addr_t araddr,
	output logic arvalid,
	input logic arready,
	input fetch_pkg::instr_t rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	output logic rready
);

	import fetch_pkg::*;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_ADDR,
		PH_DATA
	} phase_t;

	phase_t phase;
	addr_t addr_q;
	logic r_fire;

	assign req_ready = (phase == PH_IDLE);
	assign arvalid = (phase == PH_ADDR);
	assign rready = (phase == PH_DATA);
	assign araddr = addr_q;
	// error responses are treated as data, rresp left unread
	assign r_fire = rvalid && rready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= r_fire;
			case (phase)
				PH_IDLE: if (req_valid) phase <= PH_ADDR;
				PH_ADDR: if (arready) phase <= PH_DATA;
				PH_DATA: if (rvalid) phase <= PH_IDLE;
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			addr_q <= req_addr;
		if (r_fire)
			resp_data <= rdata;
	end

endmodule

// File: rtl/instr_queue.sv
/* circular FIFO of pc/instr entries, head read combinationally
   flush beats push; push when full and pop when empty are ignored */
`timescale 1ns/1ns
`include "fetch_params.svh"

module instr_queue (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic push,
	input fetch_pkg::queue_entry_t push_entry,
	input logic pop,
	output fetch_pkg::queue_entry_t head,
	output logic not_empty,
	output logic almost_full
);

	import fetch_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

	queue_entry_t mem [`QUEUE_DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_push, do_pop;

	assign do_push = push && (count != CNT_W'(`QUEUE_DEPTH));
	assign do_pop = pop && not_empty;

	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);
	// one slot kept free for the read still in flight
	assign almost_full = (count >= CNT_W'(`QUEUE_DEPTH - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push && !flush)
			mem[wr_ptr] <= push_entry;
	end

endmodule

// File: rtl/instr_predecode.sv
/* static prediction: JAL and backward branches taken
   is_branch covers JAL as well as conditional branches */
`timescale 1ns/1ns
`include "fetch_params.svh"

module instr_predecode (
	input fetch_pkg::queue_entry_t head,
	input logic not_empty,
	input logic redirect_valid,
	output fetch_pkg::issue_t issue,
	output logic issue_valid
);

	import fetch_pkg::*;

	logic [6:0] opcode;
	logic is_jal, is_cond;
	addr_t imm_j, imm_b;
	addr_t imm;

	assign opcode = head.instr[6:0];
	assign is_jal = (opcode == `OP_JAL);
	assign is_cond = (opcode == `OP_BRANCH);

	// J-type and B-type immediates, bit 0 always zero
	assign imm_j = {{12{head.instr[31]}}, head.instr[19:12], head.instr[20],
		head.instr[30:21], 1'b0};
	assign imm_b = {{20{head.instr[31]}}, head.instr[7], head.instr[30:25],
		head.instr[11:8], 1'b0};
	assign imm = is_jal ? imm_j : imm_b;

	always_comb begin
		issue.pc = head.pc;
		issue.instr = head.instr;
		issue.is_ecall = (head.instr == `INSTR_ECALL);
		issue.is_branch = is_jal || is_cond;
		// sign bit set means a backward branch
		issue.taken = is_jal || (is_cond && head.instr[31]);
		if (is_jal || is_cond)
			issue.target = head.pc + imm;
		else
			issue.target = head.pc + `XLEN'd4;
	end

	// the queue is being flushed this cycle
	assign issue_valid = not_empty && !redirect_valid;

endmodule

// File: rtl/fetch_top.sv
/* fetch front end: controller, AXI-Lite read master, queue, predecode
   no write channels; redirect has no ready and is taken every cycle */
`timescale 1ns/1ns

module fetch_top (
	input logic clk,
	input logic rst_n,
	input logic go,
	input logic redirect_valid,
	input fetch_pkg::addr_t redirect_pc,
	output fetch_pkg::addr_t araddr,
	output logic arvalid,
	input logic arready,
	input fetch_pkg::instr_t rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	output logic rready,
	output fetch_pkg::issue_t issue,
	output logic issue_valid,
	input logic issue_ready
);

	import fetch_pkg::*;

	logic req_valid, req_ready;
	addr_t req_addr;
	logic resp_valid;
	instr_t resp_data;
	logic push, flush, pop;
	queue_entry_t push_entry, head;
	logic not_empty, almost_full;

	assign pop = issue_valid && issue_ready;

	fetch_ctrl i_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.push(push),
		.push_entry(push_entry),
		.flush(flush),
		.almost_full(almost_full)
	);

	axil_read_master i_axil (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	instr_queue i_queue (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.push(push),
		.push_entry(push_entry),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.almost_full(almost_full)
	);

	instr_predecode i_predecode (
		.head(head),
		.not_empty(not_empty),
		.redirect_valid(redirect_valid),
		.issue(issue),
		.issue_valid(issue_valid)
	);

endmodule

// File: tb/tb_checker.sv
/* reference model of the issue stream; memory words come from tb_top.mem_img
   expects no issue before the first go and samples on the falling edge */
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_checker (
	input logic clk,
	input logic rst_n,
	input logic go,
	input logic redirect_valid,
	input fetch_pkg::addr_t redirect_pc,
	input fetch_pkg::issue_t issue,
	input logic issue_valid,
	input logic issue_ready,
	output int value_errors,
	output int stall_errors,
	output int issued,
	output logic halted
);

	import fetch_pkg::*;

	addr_t exp_pc;
	issue_t want;
	issue_t held_issue;
	logic held;

	// static prediction from the word and its pc
	function automatic issue_t predict(input addr_t pc, input instr_t w);
		issue_t r;
		logic [31:0] imm;
		r.pc = pc;
		r.instr = w;
		r.is_ecall = (w == `INSTR_ECALL);
		r.is_branch = 1'b0;
		r.taken = 1'b0;
		r.target = pc + 32'd4;
		if (w[6:0] == `OP_JAL) begin
			imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			r.is_branch = 1'b1;
			r.taken = 1'b1;
			r.target = pc + imm;
		end else if (w[6:0] == `OP_BRANCH) begin
			imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			r.is_branch = 1'b1;
			r.taken = imm[31];
			r.target = pc + imm;
		end
		return r;
	endfunction

	task automatic compare_field(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			value_errors = value_errors + 1;
			$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, what, exp, act);
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			exp_pc = `BOOT_PC;
			halted = 1'b1;
			held = 1'b0;
			value_errors = 0;
			stall_errors = 0;
			issued = 0;
		end else begin
			// a stalled issue must keep its payload
			if (held && !redirect_valid) begin
				if (!issue_valid || issue !== held_issue) begin
					stall_errors = stall_errors + 1;
					$display("issue payload changed or valid dropped while stalled at %0t ns",
						$time);
				end
			end
			if (redirect_valid) begin
				exp_pc = redirect_pc;
				if (issue_valid) begin
					value_errors = value_errors + 1;
					$display("issue_valid is high in a redirect cycle at %0t ns", $time);
				end
			end else if (issue_valid && issue_ready) begin
				issued = issued + 1;
				if (halted) begin
					value_errors = value_errors + 1;
					$display("word at pc %h issued while fetch should be halted, %0t ns",
						issue.pc, $time);
				end
				want = predict(exp_pc, tb_top.mem_img[exp_pc[9:2]]);
				compare_field("pc", want.pc, issue.pc);
				compare_field("instr", want.instr, issue.instr);
				compare_field("is_ecall", want.is_ecall, issue.is_ecall);
				compare_field("is_branch", want.is_branch, issue.is_branch);
				compare_field("taken", want.taken, issue.taken);
				compare_field("target", want.target, issue.target);
				exp_pc = exp_pc + 32'd4;
				if (want.is_ecall)
					halted = 1'b1;
			end
			held = issue_valid && !issue_ready && !redirect_valid;
			held_issue = issue;
			if (go)
				halted = 1'b0;
		end
	end

endmodule

// File: tb/tb_top.sv
/* memory window of 256 words that aliases above 0x3ff
   reads tb/fetch_input.txt relative to the project root */
`timescale 1ns/1ns

module tb_top;

	import fetch_pkg::*;

	logic clk;
	logic rst_n;
	logic go;
	logic redirect_valid;
	addr_t redirect_pc;
	addr_t araddr;
	logic arvalid, arready;
	instr_t rdata;
	logic [1:0] rresp;
	logic rvalid, rready;
	issue_t issue;
	logic issue_valid, issue_ready;

	logic [31:0] raw [0:127];
	instr_t mem_img [0:255];
	logic [31:0] sched_cyc [0:31];
	logic [31:0] sched_kind [0:31];
	logic [31:0] sched_arg [0:31];
	int n_mem, n_sched, sched_idx, sched_errors;
	logic [31:0] cyc, last_cyc;
	logic loaded;

	// memory model state
	logic pending;
	logic [1:0] delay;
	addr_t rd_addr;
	logic [31:0] rnd;

	int value_errors, stall_errors, issued, total;
	logic halted;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// never equals the ECALL word
	function automatic instr_t fill_word(input logic [31:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h0000_0013;
	endfunction

	task automatic load_stimulus();
		int base;
		addr_t a;
		$readmemh("tb/fetch_input.txt", raw);
		for (int i = 0; i < 256; i++)
			mem_img[i] = fill_word(i * 4);
		loaded = !$isunknown(raw[0]) && raw[0] <= 32'd50;
		if (loaded) begin
			n_mem = raw[0];
			for (int i = 0; i < n_mem; i++) begin
				a = raw[2 + 2 * i];
				mem_img[a[9:2]] = raw[1 + 2 * i];
			end
			base = 1 + 2 * n_mem;
			loaded = !$isunknown(raw[base]) && raw[base] >= 1 && raw[base] <= 32;
		end
		if (loaded) begin
			n_sched = raw[base];
			for (int j = 0; j < n_sched; j++) begin
				sched_cyc[j] = raw[base + 1 + 3 * j];
				sched_kind[j] = raw[base + 2 + 3 * j];
				sched_arg[j] = raw[base + 3 + 3 * j];
			end
			last_cyc = sched_cyc[n_sched - 1];
		end
	endtask

	task automatic apply_event(input logic [31:0] kind, input logic [31:0] arg);
		case (kind)
			32'd1: go <= 1'b1;
			32'd2: begin
				redirect_valid <= 1'b1;
				redirect_pc <= arg;
			end
			32'd3: issue_ready <= 1'b0;
			32'd4: issue_ready <= 1'b1;
			default: begin
				sched_errors = sched_errors + 1;
				$display("unknown schedule event kind %0d at cycle %0d", kind, cyc);
			end
		endcase
	endtask

	always #50 clk = ~clk;

	fetch_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.issue(issue),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready)
	);

	tb_checker i_checker (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.issue(issue),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.value_errors(value_errors),
		.stall_errors(stall_errors),
		.issued(issued),
		.halted(halted)
	);

	// schedule cycles are counted from reset release
	always @(posedge clk) begin
		if (rst_n) begin
			go <= 1'b0;
			redirect_valid <= 1'b0;
			while (sched_idx < n_sched && sched_cyc[sched_idx] == cyc) begin
				apply_event(sched_kind[sched_idx], sched_arg[sched_idx]);
				sched_idx = sched_idx + 1;
			end
			cyc = cyc + 1;
		end
	end

	// AXI-Lite read slave with 0 to 3 random cycles before rvalid
	always @(posedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			pending <= 1'b0;
			delay <= 2'd0;
		end else begin
			arready <= 1'b1;
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (pending) begin
				if (delay == 2'd0) begin
					rvalid <= 1'b1;
					rdata <= mem_img[rd_addr[9:2]];
					// any response code, the data stays valid
					rresp <= rnd[25:24];
					pending <= 1'b0;
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (arvalid && arready) begin
				pending <= 1'b1;
				rd_addr <= araddr;
				rnd = lcg_next(rnd);
				delay <= rnd[17:16];
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		go = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		arready = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		rvalid = 1'b0;
		issue_ready = 1'b1;
		rnd = 32'h132a_d05f;
		cyc = '0;
		sched_idx = 0;
		sched_errors = 0;
		n_sched = 0;
		load_stimulus();
		if (!loaded) begin
			sched_errors = sched_errors + 1;
			$display("could not read a valid stimulus file at tb/fetch_input.txt");
		end else begin
			repeat (10) @(posedge clk);
			rst_n <= 1'b1;
			@(negedge clk);
			// done when the schedule is over and the last ECALL has left the queue
			while (cyc <= last_cyc + 2 || !halted || issue_valid)
				@(negedge clk);
			// quiet period in which nothing may issue
			repeat (20) @(negedge clk);
		end
		total = value_errors + stall_errors + sched_errors;
		$display("issued %0d words, value errors %0d, stall errors %0d, schedule errors %0d",
			issued, value_errors, stall_errors, sched_errors);
		if (total == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog
	initial begin
		wait (loaded === 1'b1);
		#((last_cyc + 200) * 100);
		$display("run timed out before fetch halted after the last schedule event");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_ctrl.sv
rtl/axil_read_master.sv
rtl/instr_queue.sv
rtl/instr_predecode.sv
rtl/fetch_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: tb/fetch_input.txt
// memory: count, then word/address pairs; schedule: count, then cycle/kind/arg
// kind 1 go, 2 redirect to arg, 3 issue_ready low, 4 issue_ready high
00000009
00100093 00000100
010000EF 00000104
FE000CE3 00000108
00208463 0000010C
00000073 00000140
FF1FF0EF 00000150
FE000CE3 00000208
00000073 00000220
00000073 00000190
00000009
00000002 00000001 00000000
00000014 00000003 00000000
0000003C 00000004 00000000
000000FA 00000001 00000000
00000122 00000003 00000000
0000012C 00000002 00000200
00000140 00000004 00000000
000001A4 00000002 00000180
000001B8 00000001 00000000
